/* afc.f */
verilog/afc_pkg.sv
verilog/edge_detect.sv
verilog/freq_compare.sv
verilog/band_search.sv
verilog/afc_top.sv
bench/vco_model.sv
bench/afc_tb.sv

/* bench/afc_tb.sv */
`default_nettype none

module afc_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int clk_period    = 8;
  localparam int done_timeout  = 20000;  // Cycles allowed per run
  localparam int random_runs   = 8;
  localparam int quiet_cycles  = 64;     // Watch after done for stray activity
  localparam int band_max      = 2 ** afc_pkg::band_w - 1;

  logic           clk;
  logic           rst;
  logic           fref;
  logic           fdiv;
  logic           start;
  afc_pkg::band_t band;
  logic           busy;
  logic           done;
  logic           locked;

  int             target;
  logic           stop_div;
  integer         seed;
  int             done_count;

  afc_top dut (
    .clk    (clk),
    .rst    (rst),
    .fref   (fref),
    .fdiv   (fdiv),
    .start  (start),
    .band   (band),
    .busy   (busy),
    .done   (done),
    .locked (locked)
  );

  vco_model vco (
    .band     (band),
    .target   (target),
    .stop_div (stop_div),
    .fref     (fref),
    .fdiv     (fdiv)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  always @(negedge clk) begin
    if (!rst && done) begin
      done_count++;
    end
  end

  task automatic stop_on_failure();
    $display("Checks failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input int expected, input int actual);
    assert (expected == actual) else begin
      $display("MISMATCH %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
      stop_on_failure();
    end
  endtask

  // done is a one-cycle pulse
  done_single: assert property (@(posedge clk) disable iff (rst) done |=> !done)
    else begin
      $display("done stayed high for more than one cycle");
      stop_on_failure();
    end

  // done comes with the fall of busy
  done_with_busy_fall: assert property (
    @(posedge clk) disable iff (rst) done |-> (!busy && $past(busy)))
    else begin
      $display("done pulse did not coincide with busy falling");
      stop_on_failure();
    end

  // Every run starts at mid-scale
  run_starts_mid: assert property (
    @(posedge clk) disable iff (rst) $rose(busy) |-> band == afc_pkg::band_start)
    else begin
      $display("MISMATCH band: expected 0x%0h, actual 0x%0h",
               afc_pkg::band_start, $sampled(band));
      stop_on_failure();
    end

  // Expected band and locked from the slow/fast/freeze rule
  function automatic logic predict_search(input int tgt, input logic stopped,
                                          output int final_band);
    int   b;
    int   step;
    logic lock;
    b    = afc_pkg::band_start;
    lock = 1'b0;
    for (int i = 0; i < afc_pkg::num_steps; i++) begin
      if (!lock) begin
        step = (i < 4) ? (8 >> i) : 1;  // 8, 4, 2, 1, 1
        if (!stopped && b == tgt) begin
          lock = 1'b1;
        end else if (stopped || b < tgt) begin
          b = (b + step > band_max) ? band_max : b + step;
        end else begin
          b = (b < step) ? 0 : b - step;
        end
      end
    end
    final_band = b;
    return lock;
  endfunction

  task automatic pulse_start();
    @(posedge clk);
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
  endtask

  task automatic wait_for_done(input string what);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (!done) begin
      if (cycles >= done_timeout) begin
        $display("Timeout: %s did not arrive within %0d cycles", what, done_timeout);
        stop_on_failure();
      end
      cycles++;
      @(negedge clk);
    end
  endtask

  // One full calibration run with an optional stray start
  task automatic run_calibration(input int tgt, input logic stopped, input logic disturb);
    int   exp_band;
    logic exp_locked;
    int   count_before;
    int   cycles;
    exp_locked = predict_search(tgt, stopped, exp_band);
    @(posedge clk);
    target   <= tgt;
    stop_div <= stopped;
    count_before = done_count;
    pulse_start();
    @(negedge clk);
    check_value("busy", 1, busy);
    check_value("band", afc_pkg::band_start, band);
    if (disturb) begin
      cycles = 0;
      @(negedge clk);
      while (band == afc_pkg::band_start) begin  // First decision still pending
        if (cycles >= done_timeout) begin
          $display("Timeout: first band decision did not arrive within %0d cycles",
                   done_timeout);
          stop_on_failure();
        end
        cycles++;
        @(negedge clk);
      end
      @(posedge clk);
      start <= 1'b1;  // Should be ignored
      @(posedge clk);
      start <= 1'b0;
      @(negedge clk);
      check_value("busy", 1, busy);
      check_value("band", (tgt > afc_pkg::band_start) ? 24 : 8, band);  // First step of 8
    end
    wait_for_done($sformatf("done for target %0d", tgt));
    check_value("band", exp_band, band);
    check_value("locked", exp_locked, locked);
    check_value("busy", 0, busy);
    repeat (quiet_cycles) @(negedge clk);
    check_value("busy", 0, busy);
    check_value("done_count", 1, done_count - count_before);
    check_value("band", exp_band, band);  // Held until next start
  endtask

  initial begin
    int directed [4];
    directed    = '{16, 24, 31, 1};
    rst         = 1'b1;
    start       = 1'b0;
    target      = 16;
    stop_div    = 1'b0;
    seed        = 32'h2c35_e4f3;
    done_count  = 0;

    repeat (4) @(posedge clk);
    rst <= 1'b0;

    // Reset state
    @(negedge clk);
    check_value("band", afc_pkg::band_start, band);
    check_value("busy", 0, busy);
    check_value("done", 0, done);
    check_value("locked", 0, locked);

    foreach (directed[i]) begin
      run_calibration(directed[i], 1'b0, 1'b0);
    end

    repeat (random_runs) begin
      run_calibration(1 + ($unsigned($random(seed)) % 31), 1'b0, 1'b0);
    end

    // Target 0 is never measured before the steps run out
    run_calibration(0, 1'b0, 1'b0);

    // Band climbs to the top without div edges
    run_calibration(20, 1'b1, 1'b0);

    // Stray start while busy
    run_calibration(20, 1'b0, 1'b0);
    run_calibration(20, 1'b0, 1'b1);

    // Back to back with new targets
    run_calibration(27, 1'b0, 1'b0);
    run_calibration(3, 1'b0, 1'b0);
    run_calibration(12, 1'b0, 1'b0);

    $display("All checks passed");
    $finish;
  end

endmodule

`default_nettype wire

/* bench/vco_model.sv */
`default_nettype none

module vco_model (
  input  afc_pkg::band_t band,
  input  int             target,    // Band at which fdiv matches fref
  input  logic           stop_div,  // Holds fdiv low while set
  output logic           fref,
  output logic           fdiv
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam int ref_half   = 80;   // 160 ns reference period
  localparam int base_per   = 160;
  localparam int gain_per   = 24;   // Period change per band of error
  localparam int min_period = 40;
  localparam int max_period = 800;

  // Lower band than target gives a longer period, so the VCO looks slow
  function automatic int div_period(input int tgt, input int bnd);
    int period;
    period = base_per + gain_per * (tgt - bnd);
    if (period < min_period) begin
      period = min_period;
    end
    if (period > max_period) begin
      period = max_period;
    end
    return period;
  endfunction

  initial begin
    fref = 1'b0;
    forever #ref_half fref = ~fref;
  end

  // Half period is looked up every ns, so a band change takes effect
  // within the running half cycle
  initial begin
    int elapsed;
    elapsed = 0;
    fdiv    = 1'b0;
    forever begin
      #1;
      if (stop_div) begin
        fdiv    = 1'b0;
        elapsed = 0;
      end else begin
        elapsed++;
        if (elapsed >= div_period(target, int'(band)) / 2) begin
          fdiv    = ~fdiv;
          elapsed = 0;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/afc_pkg.sv */
`default_nettype none

package afc_pkg;

  // Band select width and value type
  localparam int band_w = 5;

  typedef logic [band_w-1:0] band_t;

  // Every run begins at mid-scale
  localparam band_t band_start = band_t'(16);

  // Steps 8, 4, 2, 1, 1 give at most five decisions
  localparam int num_steps = 5;

  // Outcome of one frequency measurement
  typedef enum logic [1:0] {
    verdict_slow,   // VCO below reference, raise band
    verdict_fast,   // VCO above reference, lower band
    verdict_freeze  // Within tolerance
  } verdict_e;

endpackage

`default_nettype wire

/* verilog/afc_top.sv */
`default_nettype none

module afc_top #(
  parameter int WINDOW    = 16,  // Ref edge intervals per measurement
  parameter int TOLERANCE = 1,   // Allowed div count deviation
  parameter int COUNT_W   = 8    // Edge counter width
) (
  input  logic           clk,
  input  logic           rst,
  input  logic           fref,
  input  logic           fdiv,
  input  logic           start,
  output afc_pkg::band_t band,
  output logic           busy,
  output logic           done,
  output logic           locked
);

  logic              ref_edge;
  logic              div_edge;
  logic              meas_start;
  logic              verdict_valid;
  afc_pkg::verdict_e verdict;

  // Reference clock into the clk domain
  edge_detect ref_sync (
    .clk        (clk),
    .rst        (rst),
    .sig        (fref),
    .edge_pulse (ref_edge)
  );

  // Divided VCO clock into the clk domain
  edge_detect div_sync (
    .clk        (clk),
    .rst        (rst),
    .sig        (fdiv),
    .edge_pulse (div_edge)
  );

  // One verdict per meas_start
  freq_compare #(
    .WINDOW    (WINDOW),
    .TOLERANCE (TOLERANCE),
    .COUNT_W   (COUNT_W)
  ) compare (
    .clk           (clk),
    .rst           (rst),
    .meas_start    (meas_start),
    .ref_edge      (ref_edge),
    .div_edge      (div_edge),
    .verdict_valid (verdict_valid),
    .verdict       (verdict)
  );

  // Binary search over the band select
  band_search search (
    .clk           (clk),
    .rst           (rst),
    .start         (start),
    .verdict_valid (verdict_valid),
    .verdict       (verdict),
    .meas_start    (meas_start),
    .band          (band),
    .busy          (busy),
    .done          (done),
    .locked        (locked)
  );

endmodule

`default_nettype wire

/* verilog/band_search.sv */
`default_nettype none

module band_search (
  input  logic              clk,
  input  logic              rst,
  input  logic              start,
  input  logic              verdict_valid,
  input  afc_pkg::verdict_e verdict,
  output logic              meas_start,
  output afc_pkg::band_t    band,
  output logic              busy,
  output logic              done,
  output logic              locked
);

  localparam int dec_w = $clog2(afc_pkg::num_steps);
  localparam logic [dec_w-1:0] dec_last = dec_w'(afc_pkg::num_steps - 1);

  logic [dec_w-1:0]         dec_cnt;        // Decisions taken in this run
  afc_pkg::band_t           step;
  afc_pkg::band_t           band_nxt;
  logic [afc_pkg::band_w:0] band_sum;       // Carry bit flags overflow
  logic                     last_decision;

  // Halve mid-scale once per decision, never below one
  always_comb begin
    step = afc_pkg::band_start >> (dec_cnt + 1'b1);
    if (step == '0) begin
      step = afc_pkg::band_t'(1);
    end
  end

  // Next band for a SLOW or FAST verdict, clamped to the band range
  always_comb begin
    band_sum = {1'b0, band} + {1'b0, step};
    case (verdict)
      afc_pkg::verdict_slow: begin
        if (band_sum[afc_pkg::band_w]) begin
          band_nxt = '1;  // Top band
        end else begin
          band_nxt = band_sum[afc_pkg::band_w-1:0];
        end
      end
      afc_pkg::verdict_fast: begin
        if (band < step) begin
          band_nxt = '0;  // Bottom band
        end else begin
          band_nxt = band - step;
        end
      end
      default: begin
        band_nxt = band;
      end
    endcase
  end

  assign last_decision = (dec_cnt == dec_last);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      busy       <= 1'b0;
      done       <= 1'b0;
      locked     <= 1'b0;
      meas_start <= 1'b0;
      band       <= afc_pkg::band_start;
      dec_cnt    <= '0;
    end else begin
      meas_start <= 1'b0;
      done       <= 1'b0;
      if (!busy) begin
        if (start) begin
          busy       <= 1'b1;
          meas_start <= 1'b1;  // First measurement right away
          band       <= afc_pkg::band_start;
          dec_cnt    <= '0;
          locked     <= 1'b0;
        end
      end else if (verdict_valid) begin
        if (verdict == afc_pkg::verdict_freeze) begin
          busy   <= 1'b0;  // Band is on target
          done   <= 1'b1;
          locked <= 1'b1;
        end else begin
          band    <= band_nxt;
          dec_cnt <= dec_cnt + 1'b1;
          if (last_decision) begin
            busy <= 1'b0;  // Out of steps, not locked
            done <= 1'b1;
          end else begin
            meas_start <= 1'b1;  // Measure the new band
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/edge_detect.sv */
`default_nettype none

module edge_detect (
  input  logic clk,
  input  logic rst,
  input  logic sig,
  output logic edge_pulse
);

  logic sync_1;     // First synchronizer stage, may go metastable
  logic sync_2;     // Settled level
  logic sync_prev;  // Level one cycle earlier

  // Two flops bring the square wave into the clk domain, the third holds
  // the last settled level so a low-to-high step can be seen
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      sync_1     <= 1'b0;
      sync_2     <= 1'b0;
      sync_prev  <= 1'b0;
      edge_pulse <= 1'b0;
    end else begin
      sync_1     <= sig;
      sync_2     <= sync_1;
      sync_prev  <= sync_2;
      edge_pulse <= sync_2 & ~sync_prev;  // One cycle per rising edge
    end
  end

endmodule

`default_nettype wire

/* verilog/freq_compare.sv */
`default_nettype none

module freq_compare #(
  parameter int WINDOW    = 16,
  parameter int TOLERANCE = 1,
  parameter int COUNT_W   = 8
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              meas_start,
  input  logic              ref_edge,
  input  logic              div_edge,
  output logic              verdict_valid,
  output afc_pkg::verdict_e verdict
);

  localparam logic [COUNT_W-1:0] cnt_max  = '1;
  localparam logic [COUNT_W-1:0] ref_last = COUNT_W'(WINDOW - 1);
  localparam logic [COUNT_W-1:0] lo_limit = COUNT_W'(WINDOW - TOLERANCE);
  localparam logic [COUNT_W-1:0] hi_limit = COUNT_W'(WINDOW + TOLERANCE);

  typedef enum logic [1:0] {
    st_idle,    // Waiting for meas_start
    st_arm,     // Waiting for the ref edge that opens the window
    st_count,   // Window open
    st_report   // Verdict on the outputs
  } state_e;

  state_e             state;
  state_e             state_nxt;
  logic [COUNT_W-1:0] ref_cnt;   // Ref edges since window opened
  logic [COUNT_W-1:0] div_cnt;   // Div edges since window opened
  logic               window_close;

  // Counters stick at full scale instead of wrapping
  function automatic logic [COUNT_W-1:0] sat_inc(input logic [COUNT_W-1:0] value);
    if (value == cnt_max) begin
      return value;
    end
    return value + 1'b1;
  endfunction

  // The WINDOW-th ref edge after the opening one closes the window
  assign window_close = (state == st_count) && ref_edge && (ref_cnt == ref_last);

  always_comb begin
    state_nxt = state;
    case (state)
      st_idle: begin
        if (meas_start) state_nxt = st_arm;
      end
      st_arm: begin
        if (ref_edge) state_nxt = st_count;
      end
      st_count: begin
        if (window_close) state_nxt = st_report;
      end
      st_report: begin
        state_nxt = st_idle;  // Single verdict cycle
      end
      default: begin
        state_nxt = st_idle;
      end
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= st_idle;
    end else begin
      state <= state_nxt;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      ref_cnt <= '0;
      div_cnt <= '0;
    end else if (state == st_arm) begin
      ref_cnt <= '0;  // Fresh counts for every measurement
      div_cnt <= '0;
    end else if (state == st_count) begin
      if (ref_edge) begin
        ref_cnt <= sat_inc(ref_cnt);
      end
      if (div_edge) begin
        div_cnt <= sat_inc(div_cnt);  // Includes an edge in the closing cycle
      end
    end
  end

  // Tolerance band around WINDOW, div count is frozen while reporting
  always_comb begin
    if (div_cnt < lo_limit) begin
      verdict = afc_pkg::verdict_slow;
    end else if (div_cnt > hi_limit) begin
      verdict = afc_pkg::verdict_fast;
    end else begin
      verdict = afc_pkg::verdict_freeze;
    end
  end

  assign verdict_valid = (state == st_report);

endmodule

`default_nettype wire
